// File: hw/cpuPkg.sv
`default_nettype none

package cpuPkg;

    localparam int WORD_SIZE  = 16;
    localparam int NUM_REGS   = 4;
    localparam int MEM_WORDS  = 256;
    localparam int MEM_ADDR_W = $clog2(MEM_WORDS);

    typedef logic [WORD_SIZE-1:0] word_t;
    typedef logic [$clog2(NUM_REGS)-1:0] regIdx_t;

    // JAL and JRL write their return address here
    localparam regIdx_t LINK_REG = 2'd2;

    localparam logic [3:0] OP_BNE   = 4'd0;
    localparam logic [3:0] OP_BEQ   = 4'd1;
    localparam logic [3:0] OP_BGZ   = 4'd2;
    localparam logic [3:0] OP_BLZ   = 4'd3;
    localparam logic [3:0] OP_ADI   = 4'd4;
    localparam logic [3:0] OP_ORI   = 4'd5;
    localparam logic [3:0] OP_LHI   = 4'd6;
    localparam logic [3:0] OP_LWD   = 4'd7;
    localparam logic [3:0] OP_SWD   = 4'd8;
    localparam logic [3:0] OP_JMP   = 4'd9;
    localparam logic [3:0] OP_JAL   = 4'd10;
    localparam logic [3:0] OP_RTYPE = 4'd15;

    localparam logic [5:0] FN_ADD = 6'd0;
    localparam logic [5:0] FN_SUB = 6'd1;
    localparam logic [5:0] FN_AND = 6'd2;
    localparam logic [5:0] FN_ORR = 6'd3;
    localparam logic [5:0] FN_NOT = 6'd4;
    localparam logic [5:0] FN_TCP = 6'd5;
    localparam logic [5:0] FN_SHL = 6'd6;
    localparam logic [5:0] FN_SHR = 6'd7;
    localparam logic [5:0] FN_JPR = 6'd25;
    localparam logic [5:0] FN_JRL = 6'd26;
    localparam logic [5:0] FN_WWD = 6'd28;
    localparam logic [5:0] FN_HLT = 6'd29;

    typedef struct packed {
        logic [3:0] opcode;
        regIdx_t    rs;
        regIdx_t    rt;
        regIdx_t    rd;
        logic [5:0] func;
    } rType_t;

    typedef struct packed {
        logic [3:0] opcode;
        regIdx_t    rs;
        regIdx_t    rt;
        logic [7:0] imm;
    } iType_t;

    typedef struct packed {
        logic [3:0]  opcode;
        logic [11:0] target;
    } jType_t;

    typedef union packed {
        rType_t rType;
        iType_t iType;
        jType_t jType;
    } instr_u;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_NOT, ALU_TCP, ALU_SHL, ALU_SHR, ALU_PASS_B
    } aluOp_e;

    typedef struct packed {
        logic regWrite, memToReg, memWrite, memRead, wwd;
        logic isBranch, isJumpReg, isJumpImm, isLink, isHalt;
        logic aluSrcImm, useRs, useRt;
    } ctrl_t;

    typedef enum logic [1:0] {FWD_REG, FWD_EXMEM, FWD_MEMWB} fwdSel_e;

    // pcNext is the address of the following instruction
    typedef struct packed {
        logic   valid;
        word_t  pcNext;
        instr_u instr;
    } ifId_t;

    typedef struct packed {
        logic    valid;
        ctrl_t   ctrl;
        word_t   pcNext;
        instr_u  instr;
        word_t   rsData;
        word_t   rtData;
        word_t   imm;
        regIdx_t rd;
    } idEx_t;

    typedef struct packed {
        logic    valid;
        ctrl_t   ctrl;
        word_t   aluOut;
        word_t   storeData;
        regIdx_t rd;
    } exMem_t;

    typedef struct packed {
        logic    valid;
        ctrl_t   ctrl;
        word_t   aluOut;
        word_t   memData;
        regIdx_t rd;
    } memWb_t;

    // Everything the hazard unit looks at
    typedef struct packed {
        regIdx_t exRs, exRt, memRd, wbRd, idRs, idRt, exRd;
        logic    exUseRs, exUseRt, memRegWrite, wbRegWrite;
        logic    idUseRs, idUseRt, exMemRead;
    } hazSrc_t;

endpackage

`default_nettype wire

// File: hw/controlUnit.sv
`default_nettype none

module controlUnit
    import cpuPkg::*;
(
    input  wire instr_u instr,
    output ctrl_t       ctrl
);

    logic isR, aluR2, aluR1, fnWwd, fnJpr, fnJrl, fnHlt;
    logic isAdiOri, isLhi, isLwd, isSwd, isBr2, isBr1, isJmp, isJal;

    always_comb begin
        isR   = instr.rType.opcode == OP_RTYPE;
        // Two-operand and one-operand R-type ALU ops
        aluR2 = isR && (instr.rType.func inside {FN_ADD, FN_SUB, FN_AND, FN_ORR});
        aluR1 = isR && (instr.rType.func inside {FN_NOT, FN_TCP, FN_SHL, FN_SHR});
        fnWwd = isR && instr.rType.func == FN_WWD;
        fnJpr = isR && instr.rType.func == FN_JPR;
        fnJrl = isR && instr.rType.func == FN_JRL;
        fnHlt = isR && instr.rType.func == FN_HLT;

        isAdiOri = instr.iType.opcode inside {OP_ADI, OP_ORI};
        isLhi    = instr.iType.opcode == OP_LHI;
        isLwd    = instr.iType.opcode == OP_LWD;
        isSwd    = instr.iType.opcode == OP_SWD;
        isBr2    = instr.iType.opcode inside {OP_BNE, OP_BEQ};
        isBr1    = instr.iType.opcode inside {OP_BGZ, OP_BLZ};
        isJmp    = instr.jType.opcode == OP_JMP;
        isJal    = instr.jType.opcode == OP_JAL;
    end

    // Anything not matched above decodes to all zeros, a no-op
    always_comb begin
        ctrl.regWrite  = aluR2 || aluR1 || fnJrl || isAdiOri || isLhi || isLwd || isJal;
        ctrl.memToReg  = isLwd;
        ctrl.memWrite  = isSwd;
        ctrl.memRead   = isLwd;
        ctrl.wwd       = fnWwd;
        ctrl.isBranch  = isBr2 || isBr1;
        ctrl.isJumpReg = fnJpr || fnJrl;
        ctrl.isJumpImm = isJmp || isJal;
        ctrl.isLink    = fnJrl || isJal;
        ctrl.isHalt    = fnHlt;
        ctrl.aluSrcImm = isAdiOri || isLhi || isLwd || isSwd;
        ctrl.useRs     = aluR2 || aluR1 || fnWwd || fnJpr || fnJrl || isAdiOri
                         || isLwd || isSwd || isBr2 || isBr1;
        ctrl.useRt     = aluR2 || isSwd || isBr2;
    end

endmodule

`default_nettype wire

// File: hw/regFile.sv
`default_nettype none

module regFile
    import cpuPkg::*;
(
    input  wire logic    clk,
    input  wire logic    rstN,
    input  wire regIdx_t rdIdxA,
    input  wire regIdx_t rdIdxB,
    output word_t        rdDataA,
    output word_t        rdDataB,
    input  wire regIdx_t wrIdx,
    input  wire word_t   wrData,
    input  wire logic    wrEn
);

    word_t regs [NUM_REGS];

    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wrEn) begin
            regs[wrIdx] <= wrData;
        end
    end

    // Writeback data seen by decode in the same cycle
    assign rdDataA = (wrEn && wrIdx == rdIdxA) ? wrData : regs[rdIdxA];
    assign rdDataB = (wrEn && wrIdx == rdIdxB) ? wrData : regs[rdIdxB];

endmodule

`default_nettype wire

// File: hw/alu.sv
`default_nettype none

module alu
    import cpuPkg::*;
(
    input  wire word_t  a,
    input  wire word_t  b,
    input  wire instr_u instr,
    output word_t       result,
    output logic        branchTaken
);

    aluOp_e op;

    always_comb begin
        op = ALU_ADD;
        if (instr.rType.opcode == OP_RTYPE) begin
            case (instr.rType.func)
                FN_SUB:  op = ALU_SUB;
                FN_AND:  op = ALU_AND;
                FN_ORR:  op = ALU_OR;
                FN_NOT:  op = ALU_NOT;
                FN_TCP:  op = ALU_TCP;
                FN_SHL:  op = ALU_SHL;
                FN_SHR:  op = ALU_SHR;
                default: op = ALU_ADD;
            endcase
        end else if (instr.iType.opcode == OP_ORI) begin
            op = ALU_OR;
        end else if (instr.iType.opcode == OP_LHI) begin
            op = ALU_PASS_B;
        end
    end

    always_comb begin
        case (op)
            ALU_SUB:    result = a - b;
            ALU_AND:    result = a & b;
            ALU_OR:     result = a | b;
            ALU_NOT:    result = ~a;
            ALU_TCP:    result = ~a + 1'b1;
            ALU_SHL:    result = {a[WORD_SIZE-2:0], 1'b0};
            // arithmetic shift
            ALU_SHR:    result = {a[WORD_SIZE-1], a[WORD_SIZE-1:1]};
            ALU_PASS_B: result = b;
            default:    result = a + b;
        endcase
    end

    always_comb begin
        case (instr.iType.opcode)
            OP_BNE:  branchTaken = a != b;
            OP_BEQ:  branchTaken = a == b;
            OP_BGZ:  branchTaken = !a[WORD_SIZE-1] && a != '0;
            OP_BLZ:  branchTaken = a[WORD_SIZE-1];
            default: branchTaken = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

// File: hw/hazardUnit.sv
`default_nettype none

module hazardUnit
    import cpuPkg::*;
(
    input  wire regIdx_t exRs,
    input  wire regIdx_t exRt,
    input  wire logic    exUseRs,
    input  wire logic    exUseRt,
    input  wire regIdx_t memRd,
    input  wire regIdx_t wbRd,
    input  wire logic    memRegWrite,
    input  wire logic    wbRegWrite,
    input  wire regIdx_t idRs,
    input  wire regIdx_t idRt,
    input  wire logic    idUseRs,
    input  wire logic    idUseRt,
    input  wire logic    exMemRead,
    input  wire regIdx_t exRd,
    output fwdSel_e      fwdA,
    output fwdSel_e      fwdB,
    output logic         stall
);

    // Younger producer in EX/MEM wins over MEM/WB
    function automatic fwdSel_e pickSrc(logic used, regIdx_t src, logic memWr, regIdx_t mRd,
                                        logic wbWr, regIdx_t wRd);
        if (used && memWr && mRd == src) return FWD_EXMEM;
        if (used && wbWr && wRd == src) return FWD_MEMWB;
        return FWD_REG;
    endfunction

    assign fwdA = pickSrc(exUseRs, exRs, memRegWrite, memRd, wbRegWrite, wbRd);
    assign fwdB = pickSrc(exUseRt, exRt, memRegWrite, memRd, wbRegWrite, wbRd);

    // Load in execute feeding the instruction in decode
    assign stall = exMemRead && ((idUseRs && idRs == exRd) || (idUseRt && idRt == exRd));

endmodule

`default_nettype wire

// File: hw/datapath.sv
`default_nettype none

module datapath
    import cpuPkg::*;
(
    input  wire logic    clk,
    input  wire logic    rstN,
    output word_t        fetchAddr,
    input  wire word_t   fetchData,
    output word_t        dataAddr,
    output word_t        dataWrData,
    output logic         dataWe,
    output logic         dataRe,
    input  wire word_t   dataRdData,
    output instr_u       decInstr,
    input  wire ctrl_t   ctrl,
    output regIdx_t      rdIdxA,
    output regIdx_t      rdIdxB,
    input  wire word_t   rdDataA,
    input  wire word_t   rdDataB,
    output regIdx_t      wrIdx,
    output word_t        wrData,
    output logic         wrEn,
    output word_t        aluA,
    output word_t        aluB,
    output instr_u       exInstr,
    input  wire word_t   aluResult,
    input  wire logic    branchTaken,
    output hazSrc_t      exSrc,
    input  wire fwdSel_e fwdA,
    input  wire fwdSel_e fwdB,
    input  wire logic    stall,
    output word_t        outputPort,
    output word_t        numInst,
    output logic         isHalted
);

    word_t   pc;
    ifId_t   ifId;
    idEx_t   idEx;
    exMem_t  exMem;
    memWb_t  memWb;
    logic    fetchStop;
    logic    exRedirect, idJump, idHalt;
    word_t   wbValue, fwdValA, fwdValB, immExt, redirTarget, jumpTarget;
    regIdx_t idRd;

    function automatic word_t pickFwd(fwdSel_e sel, word_t regVal, word_t exVal, word_t wbVal);
        case (sel)
            FWD_EXMEM: return exVal;
            FWD_MEMWB: return wbVal;
            default:   return regVal;
        endcase
    endfunction

    // Decode
    assign decInstr   = ifId.instr;
    assign rdIdxA     = ifId.instr.rType.rs;
    assign rdIdxB     = ifId.instr.rType.rt;
    assign idJump     = ifId.valid && ctrl.isJumpImm && !exRedirect;
    assign idHalt     = ifId.valid && ctrl.isHalt && !exRedirect;
    assign jumpTarget = {ifId.pcNext[WORD_SIZE-1:12], decInstr.jType.target};
    assign idRd       = ctrl.isLink ? LINK_REG :
                        (decInstr.rType.opcode == OP_RTYPE) ? decInstr.rType.rd
                                                            : decInstr.iType.rt;

    always_comb begin
        case (decInstr.iType.opcode)
            OP_ORI:  immExt = {8'h00, decInstr.iType.imm};
            OP_LHI:  immExt = {decInstr.iType.imm, 8'h00};
            default: immExt = {{8{decInstr.iType.imm[7]}}, decInstr.iType.imm};
        endcase
    end

    // Execute
    assign fwdValA     = pickFwd(fwdA, idEx.rsData, exMem.aluOut, wbValue);
    assign fwdValB     = pickFwd(fwdB, idEx.rtData, exMem.aluOut, wbValue);
    assign aluA        = fwdValA;
    assign aluB        = idEx.ctrl.aluSrcImm ? idEx.imm : (idEx.ctrl.useRt ? fwdValB : '0);
    assign exInstr     = idEx.instr;
    assign exRedirect  = idEx.valid && (idEx.ctrl.isJumpReg || (idEx.ctrl.isBranch && branchTaken));
    assign redirTarget = idEx.ctrl.isJumpReg ? fwdValA : idEx.pcNext + idEx.imm;

    assign exSrc.exRs        = idEx.instr.rType.rs;
    assign exSrc.exRt        = idEx.instr.rType.rt;
    assign exSrc.exUseRs     = idEx.ctrl.useRs;
    assign exSrc.exUseRt     = idEx.ctrl.useRt;
    assign exSrc.memRd       = exMem.rd;
    assign exSrc.wbRd        = memWb.rd;
    assign exSrc.memRegWrite = exMem.ctrl.regWrite;
    assign exSrc.wbRegWrite  = memWb.ctrl.regWrite;
    assign exSrc.idRs        = decInstr.rType.rs;
    assign exSrc.idRt        = decInstr.rType.rt;
    assign exSrc.idUseRs     = ifId.valid && ctrl.useRs;
    assign exSrc.idUseRt     = ifId.valid && ctrl.useRt;
    assign exSrc.exMemRead   = idEx.ctrl.memRead;
    assign exSrc.exRd        = idEx.rd;

    // Memory and writeback
    assign fetchAddr  = pc;
    assign dataAddr   = exMem.aluOut;
    assign dataWrData = exMem.storeData;
    assign dataWe     = exMem.ctrl.memWrite;
    assign dataRe     = exMem.ctrl.memRead;
    assign wbValue    = memWb.ctrl.memToReg ? memWb.memData : memWb.aluOut;
    assign wrIdx      = memWb.rd;
    assign wrData     = wbValue;
    assign wrEn       = memWb.ctrl.regWrite;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            pc          <= '0;
            fetchStop   <= 1'b0;
            ifId.valid  <= 1'b0;
            idEx.valid  <= 1'b0;
            idEx.ctrl   <= '0;
            exMem.valid <= 1'b0;
            exMem.ctrl  <= '0;
            memWb.valid <= 1'b0;
            memWb.ctrl  <= '0;
        end else begin
            if (!stall) begin
                if (exRedirect) begin
                    pc <= redirTarget;
                end else if (idJump) begin
                    pc <= jumpTarget;
                end else if (!(fetchStop || idHalt)) begin
                    pc <= pc + 1'b1;
                end
                if (idHalt) begin
                    fetchStop <= 1'b1;
                end
                ifId.valid  <= !(exRedirect || idJump || idHalt || fetchStop);
                ifId.pcNext <= pc + 1'b1;
                ifId.instr  <= fetchData;
            end

            // Bubble on stall, flush or empty decode slot
            if (stall || exRedirect || !ifId.valid) begin
                idEx.valid <= 1'b0;
                idEx.ctrl  <= '0;
            end else begin
                idEx.valid <= 1'b1;
                idEx.ctrl  <= ctrl;
            end
            idEx.pcNext <= ifId.pcNext;
            idEx.instr  <= ifId.instr;
            idEx.rsData <= rdDataA;
            idEx.rtData <= rdDataB;
            idEx.imm    <= immExt;
            idEx.rd     <= idRd;

            exMem.valid     <= idEx.valid;
            exMem.ctrl      <= idEx.ctrl;
            exMem.aluOut    <= idEx.ctrl.isLink ? idEx.pcNext : aluResult;
            exMem.storeData <= fwdValB;
            exMem.rd        <= idEx.rd;

            memWb.valid   <= exMem.valid;
            memWb.ctrl    <= exMem.ctrl;
            memWb.aluOut  <= exMem.aluOut;
            memWb.memData <= dataRdData;
            memWb.rd      <= exMem.rd;
        end
    end

    // Retirement
    always_ff @(posedge clk) begin
        if (!rstN) begin
            numInst    <= '0;
            outputPort <= '0;
            isHalted   <= 1'b0;
        end else if (memWb.valid) begin
            numInst <= numInst + 1'b1;
            if (memWb.ctrl.wwd) begin
                outputPort <= memWb.aluOut;
            end
            if (memWb.ctrl.isHalt) begin
                isHalted <= 1'b1;
            end
        end
    end

    exMemRwExclusive: assert property (@(posedge clk) disable iff (!rstN)
        !(exMem.ctrl.memWrite && exMem.ctrl.memRead));

    // Everything younger than HLT was flushed
    haltEndsRetirement: assert property (@(posedge clk) disable iff (!rstN)
        isHalted |-> !memWb.valid);

endmodule

`default_nettype wire

// File: hw/unifiedMemory.sv
`default_nettype none

module unifiedMemory
    import cpuPkg::*;
(
    input  wire logic                  clk,
    input  wire word_t                 fetchAddr,
    output word_t                      fetchData,
    input  wire word_t                 dataAddr,
    input  wire logic                  dataWe,
    input  wire word_t                 dataWrData,
    output word_t                      dataRdData,
    input  wire logic                  loadEn,
    input  wire logic [MEM_ADDR_W-1:0] loadAddr,
    input  wire word_t                 loadData
);

    word_t mem [MEM_WORDS];

    assign fetchData  = mem[fetchAddr[MEM_ADDR_W-1:0]];
    assign dataRdData = mem[dataAddr[MEM_ADDR_W-1:0]];

    // Load port only used while the core sits in reset
    always_ff @(posedge clk) begin
        if (loadEn) begin
            mem[loadAddr] <= loadData;
        end else if (dataWe) begin
            mem[dataAddr[MEM_ADDR_W-1:0]] <= dataWrData;
        end
    end

    writeSrcExclusive: assert property (@(posedge clk) !(loadEn && dataWe));

endmodule

`default_nettype wire

// File: hw/cpuTop.sv
`default_nettype none

module cpuTop
    import cpuPkg::*;
(
    input  wire logic                  clk,
    input  wire logic                  rstN,
    input  wire logic                  loadEn,
    input  wire logic [MEM_ADDR_W-1:0] loadAddr,
    input  wire word_t                 loadData,
    output word_t                      outputPort,
    output word_t                      numInst,
    output logic                       isHalted
);

    word_t   fetchAddr, fetchData, dataAddr, dataWrData, dataRdData;
    word_t   rdDataA, rdDataB, wrData, aluA, aluB, aluResult;
    logic    dataWe, wrEn, branchTaken, stall;
    instr_u  decInstr, exInstr;
    ctrl_t   ctrl;
    regIdx_t rdIdxA, rdIdxB, wrIdx;
    hazSrc_t exSrc;
    fwdSel_e fwdA, fwdB;

    datapath dp (
        .clk(clk), .rstN(rstN),
        .fetchAddr(fetchAddr), .fetchData(fetchData),
        .dataAddr(dataAddr), .dataWrData(dataWrData), .dataWe(dataWe), .dataRe(),
        .dataRdData(dataRdData),
        .decInstr(decInstr), .ctrl(ctrl),
        .rdIdxA(rdIdxA), .rdIdxB(rdIdxB), .rdDataA(rdDataA), .rdDataB(rdDataB),
        .wrIdx(wrIdx), .wrData(wrData), .wrEn(wrEn),
        .aluA(aluA), .aluB(aluB), .exInstr(exInstr),
        .aluResult(aluResult), .branchTaken(branchTaken),
        .exSrc(exSrc), .fwdA(fwdA), .fwdB(fwdB), .stall(stall),
        .outputPort(outputPort), .numInst(numInst), .isHalted(isHalted)
    );

    controlUnit ctrlDec (.instr(decInstr), .ctrl(ctrl));

    regFile rf (
        .clk(clk), .rstN(rstN),
        .rdIdxA(rdIdxA), .rdIdxB(rdIdxB), .rdDataA(rdDataA), .rdDataB(rdDataB),
        .wrIdx(wrIdx), .wrData(wrData), .wrEn(wrEn)
    );

    alu aluInst (
        .a(aluA), .b(aluB), .instr(exInstr),
        .result(aluResult), .branchTaken(branchTaken)
    );

    hazardUnit hazard (
        .exRs(exSrc.exRs), .exRt(exSrc.exRt),
        .exUseRs(exSrc.exUseRs), .exUseRt(exSrc.exUseRt),
        .memRd(exSrc.memRd), .wbRd(exSrc.wbRd),
        .memRegWrite(exSrc.memRegWrite), .wbRegWrite(exSrc.wbRegWrite),
        .idRs(exSrc.idRs), .idRt(exSrc.idRt),
        .idUseRs(exSrc.idUseRs), .idUseRt(exSrc.idUseRt),
        .exMemRead(exSrc.exMemRead), .exRd(exSrc.exRd),
        .fwdA(fwdA), .fwdB(fwdB), .stall(stall)
    );

    unifiedMemory mem (
        .clk(clk),
        .fetchAddr(fetchAddr), .fetchData(fetchData),
        .dataAddr(dataAddr), .dataWe(dataWe), .dataWrData(dataWrData),
        .dataRdData(dataRdData),
        .loadEn(loadEn), .loadAddr(loadAddr), .loadData(loadData)
    );

endmodule

`default_nettype wire

// File: verif/cpuTb.sv
`default_nettype none

module cpuTb
    import cpuPkg::*;
();

    localparam int CLK_PERIOD       = 100;
    localparam int RESET_CYCLES     = 4;
    localparam int ROUNDS           = 40;
    localparam int MAX_INSTR        = 70;
    localparam int CYCLES_PER_INSTR = 4;
    localparam int DATA_BASE        = 200;
    localparam int RUN_CYCLES       = MAX_INSTR * CYCLES_PER_INSTR;
    localparam int ROUND_CYCLES     = MEM_WORDS + RESET_CYCLES + 8 + RUN_CYCLES;
    localparam int WATCHDOG_CYCLES  = ROUNDS * ROUND_CYCLES;

    logic                  clk;
    logic                  rstN;
    logic                  loadEn;
    logic [MEM_ADDR_W-1:0] loadAddr;
    word_t                 loadData;
    word_t                 outputPort;
    word_t                 numInst;
    logic                  isHalted;

    logic [31:0] rngState;
    int          valueErrors;
    int          otherErrors;
    int          genPc;
    int          expCount;
    word_t       prog [MEM_WORDS];
    word_t       refMem [MEM_WORDS];
    bit          landing [MEM_WORDS];
    word_t       expWwd [$];
    word_t       expChanges [$];

    cpuTop uut (
        .clk(clk), .rstN(rstN),
        .loadEn(loadEn), .loadAddr(loadAddr), .loadData(loadData),
        .outputPort(outputPort), .numInst(numInst), .isHalted(isHalted)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) clk = ~clk;
        end
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Watchdog: run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("*** FAILED ***");
        $finish;
    end

    function automatic logic [31:0] nextRand();
        rngState = rngState ^ (rngState << 13);
        rngState = rngState ^ (rngState >> 17);
        rngState = rngState ^ (rngState << 5);
        return rngState;
    endfunction

    function automatic int randBelow(int n);
        logic [31:0] r;
        r = nextRand();
        return int'(r % n);
    endfunction

    function automatic word_t encodeR(regIdx_t rs, regIdx_t rt, regIdx_t rd, logic [5:0] func);
        return {OP_RTYPE, rs, rt, rd, func};
    endfunction

    function automatic word_t encodeI(logic [3:0] op, regIdx_t rs, regIdx_t rt, logic [7:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic word_t encodeJ(logic [3:0] op, logic [11:0] target);
        return {op, target};
    endfunction

    task automatic checkWord(string name, word_t expected, word_t actual);
        if (actual !== expected) begin
            valueErrors++;
            $display("FAIL %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic checkFlag(string name, logic expected, logic actual);
        if (actual !== expected) begin
            valueErrors++;
            $display("FAIL %s: expected %b, actual %b", name, expected, actual);
        end
    endtask

    task automatic emit(word_t w);
        prog[genPc] = w;
        genPc++;
    endtask

    // Forward-only control flow; r3 is never written and stays a zero base
    task automatic buildProgram();
        int         a, nWords, wwdGap, sinceWwd, kind, k, reach;
        regIdx_t    ra, rb, rd, lastRd;
        logic [7:0] addr;
        logic [3:0] op;
        for (a = 0; a < MEM_WORDS; a++) begin
            landing[a] = 1'b0;
            if (a >= DATA_BASE) begin
                prog[a] = word_t'(nextRand());
            end else begin
                prog[a] = {~a[7:0], a[7:0]};
            end
        end
        nWords   = 40 + randBelow(21);
        genPc    = 0;
        sinceWwd = 0;
        wwdGap   = 2 + randBelow(3);
        lastRd   = 2'd0;
        while (genPc < nWords) begin
            ra    = regIdx_t'(randBelow(4));
            rb    = regIdx_t'(randBelow(4));
            rd    = regIdx_t'(randBelow(3));
            addr  = 8'(DATA_BASE + randBelow(MEM_WORDS - DATA_BASE));
            kind  = randBelow(16);
            reach = (nWords - genPc > 8) ? 8 : nWords - genPc;
            if (sinceWwd >= wwdGap) begin
                emit(encodeR(ra, 2'd0, 2'd0, FN_WWD));
                sinceWwd = 0;
                wwdGap   = 2 + randBelow(3);
            end else begin
                sinceWwd++;
                if (kind < 5) begin
                    emit(encodeR(ra, rb, rd, 6'(randBelow(8))));
                    lastRd = rd;
                end else if (kind < 8) begin
                    op = (kind == 5) ? OP_ADI : (kind == 6) ? OP_ORI : OP_LHI;
                    emit(encodeI(op, ra, rd, 8'(randBelow(256))));
                    lastRd = rd;
                end else if (kind == 8) begin
                    emit(encodeI(OP_LWD, 2'd3, rd, addr));
                    // Load-use pair
                    if (genPc < nWords) begin
                        emit(encodeR(rd, 2'd0, 2'd0, FN_WWD));
                    end
                    lastRd = rd;
                end else if (kind == 9) begin
                    emit(encodeI(OP_SWD, 2'd3, rb, addr));
                    if (genPc < nWords) begin
                        emit(encodeI(OP_LWD, 2'd3, rd, addr));
                        lastRd = rd;
                    end
                end else if (kind == 10) begin
                    k = randBelow(reach);
                    landing[genPc + 1 + k] = 1'b1;
                    case (randBelow(4))
                        0:       op = OP_BNE;
                        1:       op = OP_BEQ;
                        2:       op = OP_BGZ;
                        default: op = OP_BLZ;
                    endcase
                    emit(encodeI(op, ra, rb, 8'(k)));
                end else if (kind == 11) begin
                    k = genPc + 1 + randBelow(reach);
                    landing[k] = 1'b1;
                    emit(encodeJ(randBelow(2) != 0 ? OP_JAL : OP_JMP, 12'(k)));
                end else if (kind == 12 && genPc + 3 <= nWords && !landing[genPc + 1]
                             && !landing[genPc + 2]) begin
                    // Target built in a register, then jumped through it
                    reach = (nWords - genPc - 2 > 8) ? 8 : nWords - genPc - 2;
                    k     = genPc + 3 + randBelow(reach);
                    landing[k] = 1'b1;
                    emit(encodeI(OP_LHI, 2'd0, rd, 8'h00));
                    emit(encodeI(OP_ORI, rd, rd, 8'(k)));
                    emit(encodeR(rd, 2'd0, 2'd0, randBelow(2) != 0 ? FN_JRL : FN_JPR));
                end else begin
                    // Back-to-back dependency on the last result
                    emit(encodeR(lastRd, rb, rd, 6'(randBelow(8))));
                    lastRd = rd;
                end
            end
        end
        prog[genPc] = encodeR(2'd0, 2'd0, 2'd0, FN_HLT);
    endtask

    // In-order ISA interpreter
    task automatic runModel();
        word_t   r [NUM_REGS];
        word_t   pc, imm, addr, prev;
        instr_u  ins;
        regIdx_t rs, rt, rd;
        logic    done;
        int      i;
        for (i = 0; i < NUM_REGS; i++) begin
            r[i] = '0;
        end
        for (i = 0; i < MEM_WORDS; i++) begin
            refMem[i] = prog[i];
        end
        pc       = '0;
        done     = 1'b0;
        expCount = 0;
        expWwd.delete();
        expChanges.delete();
        while (!done && expCount < MAX_INSTR) begin
            ins  = refMem[pc[MEM_ADDR_W-1:0]];
            rs   = ins.rType.rs;
            rt   = ins.rType.rt;
            rd   = ins.rType.rd;
            imm  = {{8{ins.iType.imm[7]}}, ins.iType.imm};
            addr = r[rs] + imm;
            pc   = pc + 16'd1;
            expCount++;
            case (ins.rType.opcode)
                OP_RTYPE: begin
                    case (ins.rType.func)
                        FN_ADD: r[rd] = r[rs] + r[rt];
                        FN_SUB: r[rd] = r[rs] - r[rt];
                        FN_AND: r[rd] = r[rs] & r[rt];
                        FN_ORR: r[rd] = r[rs] | r[rt];
                        FN_NOT: r[rd] = ~r[rs];
                        FN_TCP: r[rd] = -r[rs];
                        FN_SHL: r[rd] = r[rs] << 1;
                        FN_SHR: r[rd] = $signed(r[rs]) >>> 1;
                        FN_WWD: expWwd.push_back(r[rs]);
                        FN_JPR: pc = r[rs];
                        FN_JRL: begin
                            addr        = r[rs];
                            r[LINK_REG] = pc;
                            pc          = addr;
                        end
                        FN_HLT: done = 1'b1;
                        default: begin
                        end
                    endcase
                end
                OP_ADI: r[rt] = r[rs] + imm;
                OP_ORI: r[rt] = r[rs] | {8'h00, ins.iType.imm};
                OP_LHI: r[rt] = {ins.iType.imm, 8'h00};
                OP_LWD: r[rt] = refMem[addr[MEM_ADDR_W-1:0]];
                OP_SWD: refMem[addr[MEM_ADDR_W-1:0]] = r[rt];
                OP_BNE: pc = (r[rs] != r[rt]) ? pc + imm : pc;
                OP_BEQ: pc = (r[rs] == r[rt]) ? pc + imm : pc;
                OP_BGZ: pc = ($signed(r[rs]) > 16'sd0) ? pc + imm : pc;
                OP_BLZ: pc = ($signed(r[rs]) < 16'sd0) ? pc + imm : pc;
                OP_JMP: pc = {pc[15:12], ins.jType.target};
                OP_JAL: begin
                    r[LINK_REG] = pc;
                    pc          = {pc[15:12], ins.jType.target};
                end
                default: begin
                end
            endcase
        end
        if (!done) begin
            otherErrors++;
            $display("Model never reached HLT within %0d instructions", MAX_INSTR);
        end
        // outputPort only shows a new WWD when the value differs
        prev = '0;
        foreach (expWwd[j]) begin
            if (expWwd[j] != prev) begin
                expChanges.push_back(expWwd[j]);
            end
            prev = expWwd[j];
        end
    endtask

    task automatic loadProgram();
        int a;
        for (a = 0; a < MEM_WORDS; a++) begin
            @(negedge clk);
            loadEn   = 1'b1;
            loadAddr = a[MEM_ADDR_W-1:0];
            loadData = prog[a];
        end
        @(negedge clk);
        loadEn = 1'b0;
        repeat (RESET_CYCLES) @(negedge clk);
        rstN = 1'b1;
    endtask

    task automatic runRound(int round);
        word_t prevOut, finalOut;
        int    idx, cycles;
        prevOut  = '0;
        finalOut = (expChanges.size() > 0) ? expChanges[expChanges.size() - 1] : '0;
        idx      = 0;
        cycles   = 0;
        while (!isHalted && cycles < RUN_CYCLES) begin
            @(negedge clk);
            cycles++;
            if (outputPort !== prevOut) begin
                if (idx < expChanges.size()) begin
                    checkWord($sformatf("round %0d output %0d", round, idx), expChanges[idx],
                              outputPort);
                end else begin
                    otherErrors++;
                    $display("Round %0d: outputPort changed to %h with no WWD left to expect",
                             round, outputPort);
                end
                idx++;
                prevOut = outputPort;
            end
        end
        checkFlag($sformatf("round %0d halted", round), 1'b1, isHalted);
        checkWord($sformatf("round %0d retired count", round), word_t'(expCount), numInst);
        if (idx < expChanges.size()) begin
            otherErrors++;
            $display("Round %0d: %0d expected WWD values never reached outputPort", round,
                     expChanges.size() - idx);
        end
        repeat (4) @(negedge clk);
        checkWord($sformatf("round %0d outputPort after halt", round), finalOut, outputPort);
        checkWord($sformatf("round %0d count after halt", round), word_t'(expCount), numInst);
        checkFlag($sformatf("round %0d halted after halt", round), 1'b1, isHalted);
    endtask

    initial begin
        int round;
        rstN        = 1'b0;
        loadEn      = 1'b0;
        loadAddr    = '0;
        loadData    = '0;
        rngState    = 32'h3072;
        valueErrors = 0;
        otherErrors = 0;
        for (round = 0; round < ROUNDS; round++) begin
            @(negedge clk);
            rstN = 1'b0;
            buildProgram();
            runModel();
            loadProgram();
            runRound(round);
        end
        $display("Errors: %0d value mismatches, %0d other failures", valueErrors, otherErrors);
        if (valueErrors == 0 && otherErrors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: files.f
hw/cpuPkg.sv
hw/controlUnit.sv
hw/regFile.sv
hw/alu.sv
hw/hazardUnit.sv
hw/datapath.sv
hw/unifiedMemory.sv
hw/cpuTop.sv
verif/cpuTb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= cpuTb
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)
	@status=0; ./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || status=$$?; \
	cat $(LOG); \
	if grep -qF '*** FAILED ***' $(LOG); then \
		echo "Simulation reported failure, see $(LOG)"; \
		exit 1; \
	fi; \
	exit $$status

clean:
	rm -rf $(BUILD_DIR) $(LOG)
